//--- blk_dma.f
src/blk_dma_pkg.sv
src/backing_mem.sv
src/mem_rr_arbiter.sv
src/col_dma_port.sv
src/blk_dma_mem_system.sv
verification/tb_blk_dma_assert.sv
verification/tb_blk_dma.sv

//--- Makefile
TOP := tb_blk_dma
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the Verilator build and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f blk_dma.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/tb_blk_dma.sv
`timescale 1ns/1ns

module tb_blk_dma
  import blk_dma_pkg::*;
();

  localparam int num_cols_c       = 4;
  localparam int mem_blocks_c     = 64;
  localparam int blk_aw_c         = $clog2(mem_blocks_c);
  localparam int n_steps_c        = 16;
  localparam int timeout_cycles_c = n_steps_c * num_cols_c * (block_words_c + 8) + 100;

  logic                                                       core_clk = 1'b0;
  logic                                                       rst_n_i;
  logic [num_cols_c-1:0]                                      req;
  dma_op_e [num_cols_c-1:0]                                   op;
  logic [num_cols_c-1:0][blk_aw_c-1:0]                        blk_addr;
  logic [num_cols_c-1:0][block_words_c-1:0][word_width_c-1:0] wdata;
  logic [num_cols_c-1:0]                                      ack;
  logic [num_cols_c-1:0][block_words_c-1:0][word_width_c-1:0] rdata;

  // stimulus table with column, operation, block and issue-with-next flag
  int step_col [n_steps_c] = '{
    0, 1, 2, 3,
    1, 1,
    0, 2,
    0, 1, 2, 3,
    0, 1, 2, 3
  };
  dma_op_e step_op [n_steps_c] = '{
    dma_write, dma_write, dma_write, dma_write,
    dma_write, dma_read,
    dma_write, dma_read,
    dma_read,  dma_read,  dma_write, dma_read,
    dma_read,  dma_read,  dma_read,  dma_read
  };
  int step_blk [n_steps_c] = '{
    10, 11, 12, 13,
    20, 20,
    33, 33,
    10, 11, 40, 13,
    40, 12, 33, 20
  };
  bit step_conc [n_steps_c] = '{
    1, 1, 1, 0,
    0, 0,
    0, 0,
    1, 1, 1, 0,
    1, 1, 1, 0
  };

  // one pending command per column for the current group
  bit                                         pend_valid [num_cols_c];
  dma_op_e                                    pend_op    [num_cols_c];
  logic [blk_aw_c-1:0]                        pend_blk   [num_cols_c];
  logic [block_words_c-1:0][word_width_c-1:0] pend_data  [num_cols_c];
  logic [block_words_c-1:0][word_width_c-1:0] pend_exp   [num_cols_c];

  logic [word_width_c-1:0] ref_mem [mem_blocks_c][block_words_c];
  int                      ack_seq [$];   // columns in the order their ack rose
  int                      last_winner;
  int                      err_cnt;
  integer                  seed;

  blk_dma_mem_system #(
    .num_cols_p   (num_cols_c),
    .mem_blocks_p (mem_blocks_c)
  ) dut (
    .core_clk   (core_clk),
    .rst_n_i    (rst_n_i),
    .req_i      (req),
    .op_i       (op),
    .blk_addr_i (blk_addr),
    .wdata_i    (wdata),
    .ack_o      (ack),
    .rdata_o    (rdata)
  );

  always #2 core_clk = ~core_clk;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic load_step(input int idx);
    int c;
    int b;
    int w;
    c = step_col[idx];
    b = step_blk[idx];
    pend_valid[c] = 1'b1;
    pend_op[c]    = step_op[idx];
    pend_blk[c]   = blk_aw_c'(b);
    for (w = 0; w < block_words_c; w++) begin
      if (step_op[idx] == dma_write) begin
        pend_data[c][w] = $random(seed);
        ref_mem[b][w]   = pend_data[c][w];
      end else begin
        pend_data[c][w] = '0;
        pend_exp[c][w]  = ref_mem[b][w]; // expected read block
      end
    end
  endtask

  task automatic check_block(input int c, input string what);
    int w;
    for (w = 0; w < block_words_c; w++) begin
      check_value(rdata[c][w], pend_exp[c][w],
                  $sformatf("%s, col %0d block %0d word %0d", what, c, pend_blk[c], w));
    end
  endtask

  // four-phase client for one column
  task automatic serve_column(input int c);
    int hold_cycles;
    if (pend_valid[c]) begin
      hold_cycles = 1 + (c % 2);  // keep req up a little past ack
      @(posedge core_clk);
      #1;
      op[c]       = pend_op[c];
      blk_addr[c] = pend_blk[c];
      wdata[c]    = pend_data[c];
      req[c]      = 1'b1;
      do begin
        @(posedge core_clk);
        #1;
      end while (!ack[c]);
      ack_seq.push_back(c);
      if (pend_op[c] == dma_read) begin
        check_block(c, "read data");
      end
      repeat (hold_cycles) begin
        @(posedge core_clk);
        #1;
        check_value(ack[c], 1'b1, $sformatf("col %0d ack fell while req high", c));
        if (pend_op[c] == dma_read) begin
          check_block(c, "read data not held");
        end
      end
      req[c] = 1'b0;
      @(posedge core_clk);
      #1;
      check_value(ack[c], 1'b0, $sformatf("col %0d ack high a cycle after req fell", c));
    end
  endtask

  // round-robin from the last winner over the columns of this group
  task automatic check_order();
    int start;
    int k;
    int n;
    int cand;
    start = last_winner;
    n     = 0;
    for (k = 1; k <= num_cols_c; k++) begin
      cand = (start + k) % num_cols_c;
      if (pend_valid[cand]) begin
        check_value(ack_seq[n], cand, $sformatf("ack order position %0d", n));
        n++;
        last_winner = cand;
      end
    end
    ack_seq.delete();
  endtask

  initial begin
    int i;
    int c;
    seed        = 32'h6b93;
    err_cnt     = 0;
    last_winner = num_cols_c - 1;  // column 0 wins first after reset
    rst_n_i     = 1'b0;
    req         = '0;
    blk_addr    = '0;
    wdata       = '0;
    for (c = 0; c < num_cols_c; c++) begin
      op[c] = dma_read;
    end
    repeat (5) @(posedge core_clk);
    #1;
    rst_n_i = 1'b1;
    @(posedge core_clk);
    #1;
    for (c = 0; c < num_cols_c; c++) begin
      check_value(ack[c], 1'b0, $sformatf("col %0d ack high after reset", c));
    end

    i = 0;
    while (i < n_steps_c) begin
      for (c = 0; c < num_cols_c; c++) begin
        pend_valid[c] = 1'b0;
      end
      // gather the entries that issue in the same cycle
      do begin
        load_step(i);
        i++;
      end while ((i < n_steps_c) && step_conc[i-1]);
      fork  // one client for each of the four columns
        serve_column(0);
        serve_column(1);
        serve_column(2);
        serve_column(3);
      join
      check_order();
    end

    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles_c) @(posedge core_clk);
    $display("timeout: the DUT did not finish all transfers within %0d cycles",
             timeout_cycles_c);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verification/tb_blk_dma_assert.sv
`timescale 1ns/1ns

module arb_grant_props #(
  parameter int num_cols_p = 4
) (
  input logic                  core_clk,
  input logic                  rst_n_i,
  input logic [num_cols_p-1:0] bus_req_i,
  input logic [num_cols_p-1:0] bus_gnt_o
);

  // at most one owner on the shared bus
  grant_onehot: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    $onehot0(bus_gnt_o))
    else $error("arbiter grant is not one-hot");

  // a new grant goes only to a column that was already requesting
  grant_to_requester: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    (bus_gnt_o & ~$past(bus_gnt_o) & ~$past(bus_req_i)) == '0)
    else $error("arbiter granted a column without a request");

  // owner keeps the bus for the whole burst
  grant_locked: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    (bus_gnt_o != '0) |=>
      ((bus_gnt_o == $past(bus_gnt_o)) || (($past(bus_gnt_o) & bus_req_i) == '0)))
    else $error("arbiter grant moved while the owner still requests");

endmodule

bind mem_rr_arbiter arb_grant_props #(
  .num_cols_p(num_cols_p)
) grant_props (
  .core_clk  (core_clk),
  .rst_n_i   (rst_n_i),
  .bus_req_i (bus_req_i),
  .bus_gnt_o (bus_gnt_o)
);

//--- src/blk_dma_mem_system.sv
`timescale 1ns/1ns

module blk_dma_mem_system
  import blk_dma_pkg::*;
#(
  parameter int num_cols_p   = 4,
  parameter int mem_blocks_p = 64
) (
  input  logic                                                       core_clk,
  input  logic                                                       rst_n_i,

  input  logic    [num_cols_p-1:0]                                   req_i,
  input  dma_op_e [num_cols_p-1:0]                                   op_i,
  input  logic    [num_cols_p-1:0][$clog2(mem_blocks_p)-1:0]         blk_addr_i,
  input  logic    [num_cols_p-1:0][block_words_c-1:0][word_width_c-1:0] wdata_i,
  output logic    [num_cols_p-1:0]                                   ack_o,
  output logic    [num_cols_p-1:0][block_words_c-1:0][word_width_c-1:0] rdata_o
);

  localparam int mem_aw_lp  = $clog2(mem_blocks_p) + word_off_width_c;
  localparam int gnt_iw_lp  = (num_cols_p > 1) ? $clog2(num_cols_p) : 1;

  logic [num_cols_p-1:0] bus_req;
  logic [num_cols_p-1:0] bus_gnt;

  logic [num_cols_p-1:0]                    col_mem_en;
  logic [num_cols_p-1:0]                    col_mem_we;
  logic [num_cols_p-1:0][mem_aw_lp-1:0]     col_mem_addr;
  logic [num_cols_p-1:0][word_width_c-1:0]  col_mem_wdata;

  logic                    mem_en;
  logic                    mem_we;
  logic [mem_aw_lp-1:0]    mem_addr;
  logic [word_width_c-1:0] mem_wdata;
  logic [word_width_c-1:0] mem_rdata;
  logic [gnt_iw_lp-1:0]    gnt_idx;

  for (genvar i = 0; i < num_cols_p; i++) begin : col_gen
    col_dma_port #(
      .mem_blocks_p(mem_blocks_p)
    ) col (
      .core_clk    (core_clk),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i[i]),
      .op_i        (op_i[i]),
      .blk_addr_i  (blk_addr_i[i]),
      .wdata_i     (wdata_i[i]),
      .ack_o       (ack_o[i]),
      .rdata_o     (rdata_o[i]),
      .bus_req_o   (bus_req[i]),
      .bus_gnt_i   (bus_gnt[i]),
      .mem_en_o    (col_mem_en[i]),
      .mem_we_o    (col_mem_we[i]),
      .mem_addr_o  (col_mem_addr[i]),
      .mem_wdata_o (col_mem_wdata[i]),
      .mem_rdata_i (mem_rdata)    // each column samples only its own burst
    );
  end

  mem_rr_arbiter #(
    .num_cols_p(num_cols_p)
  ) arb (
    .core_clk  (core_clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (bus_req),
    .bus_gnt_o (bus_gnt)
  );

  // one-hot grant to index
  always_comb begin
    gnt_idx = '0;
    for (int i = 0; i < num_cols_p; i++) begin
      if (bus_gnt[i]) begin
        gnt_idx = gnt_iw_lp'(i);
      end
    end
  end

  assign mem_en    = (|bus_gnt) & col_mem_en[gnt_idx]; // idle bus when nobody owns it
  assign mem_we    = (|bus_gnt) & col_mem_we[gnt_idx];
  assign mem_addr  = col_mem_addr[gnt_idx];
  assign mem_wdata = col_mem_wdata[gnt_idx];

  backing_mem #(
    .mem_blocks_p(mem_blocks_p)
  ) mem (
    .core_clk (core_clk),
    .en_i     (mem_en),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata)
  );

endmodule

//--- src/col_dma_port.sv
`timescale 1ns/1ns

module col_dma_port
  import blk_dma_pkg::*;
#(
  parameter int mem_blocks_p = 64
) (
  input  logic                                      core_clk,
  input  logic                                      rst_n_i,

  // client side, four-phase
  input  logic                                      req_i,
  input  dma_op_e                                   op_i,
  input  logic [$clog2(mem_blocks_p)-1:0]           blk_addr_i,
  input  logic [block_words_c-1:0][word_width_c-1:0] wdata_i,
  output logic                                      ack_o,
  output logic [block_words_c-1:0][word_width_c-1:0] rdata_o,

  // arbiter side
  output logic                                      bus_req_o,
  input  logic                                      bus_gnt_i,

  // memory side, muxed at the top level
  output logic                                      mem_en_o,
  output logic                                      mem_we_o,
  output logic [$clog2(mem_blocks_p)+word_off_width_c-1:0] mem_addr_o,
  output logic [word_width_c-1:0]                   mem_wdata_o,
  input  logic [word_width_c-1:0]                   mem_rdata_i
);

  localparam int blk_aw_lp = $clog2(mem_blocks_p);
  localparam logic [word_off_width_c-1:0] last_off_lp = word_off_width_c'(block_words_c - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_wait,   // holding bus_req until granted
    st_burst,
    st_drain,  // last read word still in flight
    st_ack
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [word_off_width_c-1:0] off_q;
  logic [word_off_width_c-1:0] rd_off_q;
  logic                        capture;

  logic [block_words_c-1:0][word_width_c-1:0] rd_blk_q;

  // client inputs are stable while req_i is high, so they drive the bus directly
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_i) begin
          state_d = st_wait;
        end
      end
      st_wait: begin
        if (bus_gnt_i) begin
          state_d = st_burst;
        end
      end
      st_burst: begin
        if (off_q == last_off_lp) begin
          state_d = (op_i == dma_read) ? st_drain : st_ack;
        end
      end
      st_drain: state_d = st_ack;
      st_ack: begin
        if (!req_i) begin
          state_d = st_idle; // ack falls one cycle after req
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
      off_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == st_burst) begin
        off_q <= (off_q == last_off_lp) ? '0 : off_q + 1'b1;
      end
    end
  end

  // read data trails its address by one cycle
  assign capture = ((state_q == st_burst) && (off_q != '0) && (op_i == dma_read))
                   || (state_q == st_drain);

  always_ff @(posedge core_clk) begin
    rd_off_q <= off_q;
    if (capture) begin
      rd_blk_q[rd_off_q] <= mem_rdata_i;
    end
  end

  assign bus_req_o   = (state_q == st_wait) || (state_q == st_burst);
  assign mem_en_o    = (state_q == st_burst);
  assign mem_we_o    = (state_q == st_burst) && (op_i == dma_write);
  assign mem_addr_o  = {blk_addr_i[blk_aw_lp-1:0], off_q};
  assign mem_wdata_o = wdata_i[off_q];

  assign ack_o   = (state_q == st_ack);
  assign rdata_o = rd_blk_q; // holds while ack_o is high

endmodule

//--- src/mem_rr_arbiter.sv
`timescale 1ns/1ns

module mem_rr_arbiter #(
  parameter int num_cols_p = 4
) (
  input  logic                  core_clk,
  input  logic                  rst_n_i,
  input  logic [num_cols_p-1:0] bus_req_i,
  output logic [num_cols_p-1:0] bus_gnt_o
);

  localparam int ptr_width_lp = (num_cols_p > 1) ? $clog2(num_cols_p) : 1;

  logic [ptr_width_lp-1:0] last_q;   // last winner
  logic [num_cols_p-1:0]   gnt_q;
  logic [num_cols_p-1:0]   gnt_d;
  logic [ptr_width_lp-1:0] pick_idx;
  logic                    pick_found;
  logic                    hold;

  // owner keeps the bus while its request stays up
  assign hold = |(gnt_q & bus_req_i);

  // first requester strictly after the last winner, wrapping
  always_comb begin
    int cand;
    pick_found = 1'b0;
    pick_idx   = last_q;
    for (int i = 1; i <= num_cols_p; i++) begin
      cand = (int'(last_q) + i) % num_cols_p;
      if (!pick_found && bus_req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = ptr_width_lp'(cand);
      end
    end
    gnt_d = '0;
    gnt_d[pick_idx] = pick_found;
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      gnt_q  <= '0;
      last_q <= ptr_width_lp'(num_cols_p - 1); // column 0 first after reset
    end else if (!hold) begin
      gnt_q <= gnt_d;
      if (pick_found) begin
        last_q <= pick_idx;
      end
    end
  end

  // a released owner loses the grant at once
  assign bus_gnt_o = gnt_q & bus_req_i;

endmodule

//--- src/backing_mem.sv
`timescale 1ns/1ns

module backing_mem
  import blk_dma_pkg::*;
#(
  parameter int mem_blocks_p = 64
) (
  input  logic                                             core_clk,
  input  logic                                             en_i,
  input  logic                                             we_i,
  input  logic [$clog2(mem_blocks_p)+word_off_width_c-1:0] addr_i,
  input  logic [word_width_c-1:0]                          wdata_i,
  output logic [word_width_c-1:0]                          rdata_o
);

  localparam int depth_lp = mem_blocks_p * block_words_c;

  logic [word_width_c-1:0] mem_q [depth_lp];
  logic [word_width_c-1:0] rdata_q;

  always_ff @(posedge core_clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i]; // one cycle read latency
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- src/blk_dma_pkg.sv
package blk_dma_pkg;

  // data word on the shared memory bus
  localparam int word_width_c = 32;

  // words moved per burst
  localparam int block_words_c = 4;

  // word index inside a block
  localparam int word_off_width_c = 2;

  typedef enum logic {
    dma_read  = 1'b0,
    dma_write = 1'b1
  } dma_op_e;

endpackage
